//--- source/draw_pkg.sv
// shared coordinate, colour and state types for the triangle renderer
// imported by each design unit that handles vertices, pixels or FSM states
package draw_pkg;

    localparam int CORDW = 16;  // coordinate width

    typedef logic signed [CORDW-1:0] coord_t;  // signed screen coordinate
    typedef logic [3:0] cidx_t;  // palette index in the framebuffer

    // shape sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_INIT,
        SEQ_DRAW,
        SEQ_DONE
    } seq_state_t;

    // triangle drawer
    typedef enum logic [1:0] {
        TRI_IDLE,
        TRI_INIT,
        TRI_EDGE,
        TRI_DONE
    } tri_state_t;

    // line rasterizer
    typedef enum logic [1:0] {
        LINE_IDLE,
        LINE_INIT,
        LINE_DRAW
    } line_state_t;

endpackage

//--- source/draw_cmd_if.sv
// triangle command from the shape sequencer to the triangle drawer
// vertices and colour hold from the start pulse until the done pulse
interface draw_cmd_if import draw_pkg::*; ();

    logic   start;  // one-cycle pulse
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    coord_t x2;
    coord_t y2;
    cidx_t  cidx;  // fill colour of the outline
    logic   done;  // one-cycle pulse after the last pixel

    modport seq (output start, x0, y0, x1, y1, x2, y2, cidx, input done);

    modport drw (input start, x0, y0, x1, y1, x2, y2, cidx, output done);

endinterface

//--- source/pixel_if.sv
// rasterized pixel stream from the triangle drawer to the pixel writer
// valid marks one pixel per cycle and carries no back-pressure
interface pixel_if import draw_pkg::*; ();

    logic   valid;
    coord_t x;
    coord_t y;
    cidx_t  cidx;

    modport src (output valid, x, y, cidx);

    modport dst (input valid, x, y, cidx);

endinterface

//--- source/shape_sequencer.sv
// holds the fixed table of triangles and starts them one after another
// also paces drawing to one pixel per frame tick once the frame wait has run out
module shape_sequencer import draw_pkg::*; #(
    parameter int FRAME_WAIT = 300
) (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   frame_tick,
    input  logic   fb_busy,
    input  logic   pix_sent,  // valid of the current pixel
    draw_cmd_if.seq cmd,
    output logic   oe,
    output logic   render_done
);

    localparam int SHAPE_CNT = 3;
    localparam int SIDW = $clog2(SHAPE_CNT);
    localparam int WAITW = $clog2(FRAME_WAIT + 1);

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        coord_t x2;
        coord_t y2;
        cidx_t  cidx;
    } shape_t;

    localparam shape_t SHAPES [SHAPE_CNT] = '{
        '{x0: coord_t'(60), y0: coord_t'(20), x1: coord_t'(280), y1: coord_t'(80),
          x2: coord_t'(160), y2: coord_t'(164), cidx: 4'h9},
        '{x0: coord_t'(70), y0: coord_t'(160), x1: coord_t'(220), y1: coord_t'(90),
          x2: coord_t'(170), y2: coord_t'(10), cidx: 4'hC},
        '{x0: coord_t'(22), y0: coord_t'(35), x1: coord_t'(62), y1: coord_t'(150),
          x2: coord_t'(98), y2: coord_t'(96), cidx: 4'h2}
    };

    seq_state_t state;
    logic [SIDW-1:0] shape_id;
    logic [WAITW-1:0] cnt_wait;  // frame ticks seen so far
    logic draw_req;

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state       <= SEQ_IDLE;
            shape_id    <= '0;
            cmd.start   <= 1'b0;
            render_done <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            case (state)
                SEQ_INIT: begin
                    cmd.start <= 1'b1;  // table entry is loaded this cycle
                    state     <= SEQ_DRAW;
                end
                SEQ_DRAW: if (cmd.done) begin
                    if (shape_id == SIDW'(SHAPE_CNT - 1)) begin
                        state       <= SEQ_DONE;
                        render_done <= 1'b1;
                    end else begin
                        shape_id <= shape_id + 1'b1;
                        state    <= SEQ_INIT;
                    end
                end
                SEQ_DONE: state <= SEQ_DONE;  // stays until reset
                default: if (frame_tick) state <= SEQ_INIT;
            endcase
        end
    end

    // command payload
    always_ff @(posedge clk_100m) begin
        if (state == SEQ_INIT) begin
            cmd.x0   <= SHAPES[shape_id].x0;
            cmd.y0   <= SHAPES[shape_id].y0;
            cmd.x1   <= SHAPES[shape_id].x1;
            cmd.y1   <= SHAPES[shape_id].y1;
            cmd.x2   <= SHAPES[shape_id].x2;
            cmd.y2   <= SHAPES[shape_id].y2;
            cmd.cidx <= SHAPES[shape_id].cidx;
        end
    end

    // one request per frame tick, consumed by the next emitted pixel
    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            cnt_wait <= '0;
            draw_req <= 1'b0;
        end else begin
            if (frame_tick) begin
                if (cnt_wait != WAITW'(FRAME_WAIT - 1)) cnt_wait <= cnt_wait + 1'b1;
                else draw_req <= 1'b1;
            end
            if (pix_sent && !fb_busy) draw_req <= 1'b0;  // a tick on this cycle is absorbed
        end
    end

    assign oe = draw_req && !fb_busy;

endmodule

//--- source/draw_line.sv
// Bresenham line rasterizer, steps one pixel per cycle with oe high
// emits both endpoints and pulses done after the last one
module draw_line import draw_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   start,
    input  logic   oe,
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    output coord_t x,
    output coord_t y,
    output logic   drawing,
    output logic   done
);

    typedef logic signed [CORDW+2:0] err_t;  // room for twice the error

    line_state_t state;
    err_t dx_in;
    err_t dy_in;
    err_t dx;  // |x1 - x0|
    err_t dy;  // -|y1 - y0|
    err_t err;
    err_t e2;
    logic right;
    logic down;
    logic step_x;
    logic step_y;
    logic at_end;

    always_comb begin
        dx_in  = (x1 > x0) ? err_t'(x1) - err_t'(x0) : err_t'(x0) - err_t'(x1);
        dy_in  = (y1 > y0) ? err_t'(y0) - err_t'(y1) : err_t'(y1) - err_t'(y0);
        e2     = err <<< 1;
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
        at_end = (x == x1) && (y == y1);
    end

    assign drawing = (state == LINE_DRAW) && oe;

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state <= LINE_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LINE_INIT: state <= LINE_DRAW;
                LINE_DRAW: if (oe && at_end) begin
                    state <= LINE_IDLE;
                    done  <= 1'b1;
                end
                default: if (start) state <= LINE_INIT;
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == LINE_INIT) begin
            x     <= x0;
            y     <= y0;
            dx    <= dx_in;
            dy    <= dy_in;
            err   <= dx_in + dy_in;
            right <= (x1 > x0);
            down  <= (y1 > y0);
        end else if (drawing && !at_end) begin
            if (step_x) x <= right ? x + coord_t'(1) : x - coord_t'(1);
            if (step_y) y <= down ? y + coord_t'(1) : y - coord_t'(1);
            err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
        end
    end

endmodule

//--- source/draw_triangle.sv
// draws one triangle outline as three lines v0-v1, v1-v2 and v2-v0
// pixels leave on the pixel bus in the order the edges are walked
module draw_triangle import draw_pkg::*; (
    input  logic clk_100m,
    input  logic rst_n,
    draw_cmd_if.drw cmd,
    input  logic oe,
    pixel_if.src pix
);

    tri_state_t state;
    logic [1:0] edge_id;
    logic line_start;
    logic line_done;
    coord_t ex0;
    coord_t ey0;
    coord_t ex1;
    coord_t ey1;

    always_comb begin
        case (edge_id)
            2'd0: begin
                ex0 = cmd.x0;
                ey0 = cmd.y0;
                ex1 = cmd.x1;
                ey1 = cmd.y1;
            end
            2'd1: begin
                ex0 = cmd.x1;
                ey0 = cmd.y1;
                ex1 = cmd.x2;
                ey1 = cmd.y2;
            end
            default: begin  // closing edge
                ex0 = cmd.x2;
                ey0 = cmd.y2;
                ex1 = cmd.x0;
                ey1 = cmd.y0;
            end
        endcase
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state      <= TRI_IDLE;
            edge_id    <= 2'd0;
            line_start <= 1'b0;
            cmd.done   <= 1'b0;
        end else begin
            line_start <= 1'b0;
            cmd.done   <= 1'b0;
            case (state)
                TRI_INIT: begin
                    line_start <= 1'b1;
                    state      <= TRI_EDGE;
                end
                TRI_EDGE: if (line_done) begin
                    if (edge_id == 2'd2) begin
                        state <= TRI_DONE;
                    end else begin
                        edge_id <= edge_id + 2'd1;
                        state   <= TRI_INIT;
                    end
                end
                TRI_DONE: begin
                    cmd.done <= 1'b1;
                    state    <= TRI_IDLE;
                end
                default: if (cmd.start) begin
                    edge_id <= 2'd0;
                    state   <= TRI_INIT;
                end
            endcase
        end
    end

    draw_line draw_line_inst (
        .clk_100m,
        .rst_n,
        .start(line_start),
        .oe,
        .x0(ex0),
        .y0(ey0),
        .x1(ex1),
        .y1(ey1),
        .x(pix.x),
        .y(pix.y),
        .drawing(pix.valid),
        .done(line_done)
    );

    assign pix.cidx = cmd.cidx;  // one colour per triangle

endmodule

//--- source/pixel_writer.sv
// clips pixels to the framebuffer area and registers the write port
// fb_we follows pix.valid by one cycle for pixels inside the bounds
module pixel_writer import draw_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180
) (
    input  logic   clk_100m,
    input  logic   rst_n,
    pixel_if.dst   pix,
    output logic   fb_we,
    output coord_t fb_x,
    output coord_t fb_y,
    output cidx_t  fb_cidx
);

    logic in_bounds;

    assign in_bounds = (pix.x >= coord_t'(0)) && (pix.x < coord_t'(FB_WIDTH))
                    && (pix.y >= coord_t'(0)) && (pix.y < coord_t'(FB_HEIGHT));

    always_ff @(posedge clk_100m) begin
        if (!rst_n) fb_we <= 1'b0;
        else fb_we <= pix.valid && in_bounds;  // clipped pixels are dropped
    end

    always_ff @(posedge clk_100m) begin
        if (pix.valid && in_bounds) begin
            fb_x    <= pix.x;
            fb_y    <= pix.y;
            fb_cidx <= pix.cidx;
        end
    end

endmodule

//--- source/triangle_render_top.sv
// top level of the triangle renderer
// feeds an external framebuffer write port, paced by frame_tick and fb_busy
module triangle_render_top import draw_pkg::*; #(
    parameter int FRAME_WAIT = 300,
    parameter int FB_WIDTH   = 320,
    parameter int FB_HEIGHT  = 180
) (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   frame_tick,  // one strobe per frame
    input  logic   fb_busy,
    output logic   fb_we,
    output coord_t fb_x,
    output coord_t fb_y,
    output cidx_t  fb_cidx,
    output logic   render_done
);

    draw_cmd_if cmd_bus ();
    pixel_if    pix_bus ();
    logic       oe;  // pixel-advance enable

    shape_sequencer #(.FRAME_WAIT(FRAME_WAIT)) shape_sequencer_inst (
        .clk_100m,
        .rst_n,
        .frame_tick,
        .fb_busy,
        .pix_sent(pix_bus.valid),
        .cmd(cmd_bus.seq),
        .oe,
        .render_done
    );

    draw_triangle draw_triangle_inst (
        .clk_100m,
        .rst_n,
        .cmd(cmd_bus.drw),
        .oe,
        .pix(pix_bus.src)
    );

    pixel_writer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) pixel_writer_inst (
        .clk_100m,
        .rst_n,
        .pix(pix_bus.dst),
        .fb_we,
        .fb_x,
        .fb_y,
        .fb_cidx
    );

endmodule

//--- verif/triangle_render_asserts.sv
// concurrent checks on the framebuffer write port and the drawing pace
// bound into pixel_writer and shape_sequencer, inputs a block lacks are tied low
module triangle_render_asserts import draw_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180
) (
    input logic   clk_100m,
    input logic   rst_n,
    input logic   fb_we,
    input coord_t fb_x,
    input coord_t fb_y,
    input logic   pix_sent,
    input logic   fb_busy,
    input logic   render_done
);

    timeunit 1ns;
    timeprecision 1ps;

    we_in_bounds: assert property (@(posedge clk_100m) disable iff (!rst_n)
        fb_we |-> (fb_x >= 0 && fb_x < coord_t'(FB_WIDTH)
                   && fb_y >= 0 && fb_y < coord_t'(FB_HEIGHT)))
        else $error("fb_we with coordinates outside the framebuffer");

    no_pixel_when_busy: assert property (@(posedge clk_100m) disable iff (!rst_n)
        fb_busy |-> !pix_sent)
        else $error("pixel emitted while fb_busy is high");

    done_sticky: assert property (@(posedge clk_100m) disable iff (!rst_n)
        render_done |=> render_done)
        else $error("render_done fell after rising");

endmodule

bind pixel_writer triangle_render_asserts #(
    .FB_WIDTH(FB_WIDTH),
    .FB_HEIGHT(FB_HEIGHT)
) writer_checks (
    .clk_100m,
    .rst_n,
    .fb_we,
    .fb_x,
    .fb_y,
    .pix_sent(1'b0),
    .fb_busy(1'b0),
    .render_done(1'b0)
);

bind shape_sequencer triangle_render_asserts pacing_checks (
    .clk_100m,
    .rst_n,
    .fb_we(1'b0),
    .fb_x('0),
    .fb_y('0),
    .pix_sent,
    .fb_busy,
    .render_done
);

//--- verif/tb_triangle_render.sv
// directed testbench for triangle_render_top with a reference Bresenham model
// runs the shape table once with fb_busy low and once with a random busy pattern
module tb_triangle_render import draw_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_WAIT = 4;
    localparam int FB_WIDTH   = 200;  // clips the x=280 vertex of shape 0
    localparam int FB_HEIGHT  = 180;

    // x0, y0, x1, y1, x2, y2, colour
    localparam int SHAPE_TBL [3][7] = '{
        '{60, 20, 280, 80, 160, 164, 9},
        '{70, 160, 220, 90, 170, 10, 12},
        '{22, 35, 62, 150, 98, 96, 2}
    };

    logic       clk_100m;
    logic       rst_n;
    logic       frame_tick;
    logic       fb_busy;
    logic       fb_we;
    coord_t     fb_x;
    coord_t     fb_y;
    cidx_t      fb_cidx;
    logic       render_done;
    logic [1:0] tick_div;
    logic       busy_random;  // random busy pattern on
    logic       tick_d1;
    logic       tick_d2;
    logic       prev_busy;
    logic       done_seen;
    logic       report_done;
    int         errors;
    int         raw_count;    // rasterized pixels before clipping
    int         clip_count;
    int         cycle_limit = 0;
    int         cycle_count;
    int         win_writes;   // writes since the last paced request window opened
    int         done_writes;  // writes seen when render_done rose
    int         exp_x[$];
    int         exp_y[$];
    int         exp_c[$];
    int         got_x[$];
    int         got_y[$];
    int         got_c[$];

    triangle_render_top #(
        .FRAME_WAIT(FRAME_WAIT),
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) triangle_render_top_inst (
        .clk_100m,
        .rst_n,
        .frame_tick,
        .fb_busy,
        .fb_we,
        .fb_x,
        .fb_y,
        .fb_cidx,
        .render_done
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    initial begin
        void'($urandom(76622));
        forever begin
            @(posedge clk_100m);
            tick_div   <= tick_div + 2'd1;
            frame_tick <= (tick_div == 2'd3);  // one tick every 4 cycles
            fb_busy    <= busy_random && ($urandom_range(2) == 0);
        end
    end

    task automatic check_value(longint actual, longint expected, string msg);
        if (actual != expected) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s (got %0d, expected %0d)",
                     $time, msg, actual, expected);
        end
    endtask

    // write port monitor, sampled away from the active edge
    always @(negedge clk_100m) begin
        if (!rst_n) begin
            got_x.delete();
            got_y.delete();
            got_c.delete();
            win_writes = 0;
            done_seen  = 1'b0;
            tick_d1    = 1'b0;
            tick_d2    = 1'b0;
            prev_busy  = 1'b0;
        end else begin
            if (tick_d2) win_writes = 0;  // a tick reaches the write port two cycles later
            if (fb_we) begin
                got_x.push_back(int'(fb_x));
                got_y.push_back(int'(fb_y));
                got_c.push_back(int'(fb_cidx));
                win_writes++;
                check_value(prev_busy, 0, "write in the cycle after fb_busy was high");
                check_value(win_writes > 1, 0, "two writes within one frame tick");
            end
            if (render_done && !done_seen) begin
                done_seen   = 1'b1;
                done_writes = got_x.size();
            end
            tick_d2   = tick_d1;
            tick_d1   = frame_tick;
            prev_busy = fb_busy;
        end
    end

    task automatic add_pixel(int x, int y, int c);
        raw_count++;
        if (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT) begin
            exp_x.push_back(x);
            exp_y.push_back(y);
            exp_c.push_back(c);
        end else begin
            clip_count++;
        end
    endtask

    // walks one edge from the first vertex, both endpoints included
    task automatic raster_edge(int x0, int y0, int x1, int y1, int c);
        int x;
        int y;
        int dx;
        int dy;
        int err;
        int e2;
        bit fin;
        x   = x0;
        y   = y0;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative magnitude
        err = dx + dy;
        fin = 1'b0;
        while (!fin) begin
            add_pixel(x, y, c);
            if (x == x1 && y == y1) begin
                fin = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x += (x1 > x0) ? 1 : -1;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y += (y1 > y0) ? 1 : -1;
                end
            end
        end
    endtask

    task automatic build_reference();
        int s;
        for (s = 0; s < 3; s++) begin
            raster_edge(SHAPE_TBL[s][0], SHAPE_TBL[s][1], SHAPE_TBL[s][2], SHAPE_TBL[s][3],
                        SHAPE_TBL[s][6]);
            raster_edge(SHAPE_TBL[s][2], SHAPE_TBL[s][3], SHAPE_TBL[s][4], SHAPE_TBL[s][5],
                        SHAPE_TBL[s][6]);
            raster_edge(SHAPE_TBL[s][4], SHAPE_TBL[s][5], SHAPE_TBL[s][0], SHAPE_TBL[s][1],
                        SHAPE_TBL[s][6]);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_100m);
        rst_n <= 1'b0;
        repeat (5) @(posedge clk_100m);
        rst_n <= 1'b1;
    endtask

    task automatic test_startup_quiet();
        int ticks;
        ticks = 0;
        while (ticks < FRAME_WAIT) begin
            @(negedge clk_100m);
            check_value(fb_we, 0, "write before the frame wait ran out");
            check_value(render_done, 0, "render_done before drawing");
            if (frame_tick) ticks++;
        end
    endtask

    task automatic wait_render_done();
        while (!done_seen) @(negedge clk_100m);  // watchdog bounds this
    endtask

    task automatic test_write_sequence(string tag);
        int n;
        check_value(got_x.size(), exp_x.size(), {tag, ": write count"});
        n = (got_x.size() < exp_x.size()) ? got_x.size() : exp_x.size();
        for (int i = 0; i < n; i++) begin
            check_value(got_x[i], exp_x[i], $sformatf("%s: x of write %0d", tag, i));
            check_value(got_y[i], exp_y[i], $sformatf("%s: y of write %0d", tag, i));
            check_value(got_c[i], exp_c[i], $sformatf("%s: colour of write %0d", tag, i));
        end
    endtask

    task automatic test_clipping();
        check_value(got_x.size(), raw_count - clip_count, "write count after clipping");
        foreach (got_x[i]) begin
            check_value(got_x[i] >= 0 && got_x[i] < FB_WIDTH && got_y[i] >= 0
                        && got_y[i] < FB_HEIGHT, 1, "write outside the framebuffer");
        end
    endtask

    task automatic test_done_and_idle();
        int ticks;
        check_value(done_writes, exp_x.size(), "writes seen when render_done rose");
        ticks = 0;
        while (ticks < 50) begin
            @(negedge clk_100m);
            check_value(render_done, 1, "render_done dropped");
            if (frame_tick) ticks++;
        end
        check_value(got_x.size(), done_writes, "writes after render_done");
    endtask

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_100m);
            cycle_count++;
        end
        report_done = 1'b1;
        $display("timeout: rendering did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        frame_tick  = 1'b0;
        fb_busy     = 1'b0;
        tick_div    = 2'd0;
        busy_random = 1'b0;
        report_done = 1'b0;
        errors      = 0;
        raw_count   = 0;
        clip_count  = 0;
        build_reference();
        cycle_limit = 40 * raw_count + 200;
        apply_reset();
        test_startup_quiet();
        wait_render_done();
        test_write_sequence("busy low");
        test_clipping();
        test_done_and_idle();
        busy_random = 1'b1;  // second pass under back-pressure
        apply_reset();
        test_startup_quiet();
        wait_render_done();
        test_write_sequence("random busy");
        test_clipping();
        test_done_and_idle();
        report_done = 1'b1;
        $display("errors: %0d, reference pixels: %0d, clipped: %0d, cycles: %0d",
                 errors, raw_count, clip_count, cycle_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    final begin
        if (!report_done) $display("** FAIL **");  // run stopped by an assertion
    end

endmodule

//--- filelist.f
source/draw_pkg.sv
source/draw_cmd_if.sv
source/pixel_if.sv
source/shape_sequencer.sv
source/draw_line.sv
source/draw_triangle.sv
source/pixel_writer.sv
source/triangle_render_top.sv
verif/triangle_render_asserts.sv
verif/tb_triangle_render.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and exits 1 on any failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_triangle_render -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_triangle_render > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "** FAIL **" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"
exit 0
